//--- fetch_buffer.f
rtl/axi_lite_pkg.sv
rtl/fetch_pkg.sv
rtl/line_requester.sv
rtl/line_queue.sv
rtl/inst_select.sv
rtl/fetch_buffer.sv
verif/axi_line_memory.sv
verif/tb_fetch_buffer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_fetch_buffer \
    -f fetch_buffer.f -o sim_fetch_buffer; then
  echo "verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/sim_fetch_buffer); then
  printf '%s\n' "$out"
  echo "simulation exited with an error"
  exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '\*\* PASS \*\*'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- verif/tb_fetch_buffer.sv
`timescale 1ns/100ps

module tb_fetch_buffer;
  import axi_lite_pkg::*;
  import fetch_pkg::*;

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 10;
  // budget for one step of a test
  localparam int          STEP_CYCLES  = 200;
  localparam int          TEST_STEPS   = 80;
  localparam logic [31:0] SEED         = 32'h8f7742f3;
  localparam logic [31:0] WORD_KEY     = 32'h5a5a_a5a5;
  localparam logic [31:0] ERR_LINE     = 32'hb000_0400;

  logic        clk;
  logic        rst_n;
  axi_ar_t     ar;
  logic        ar_ready;
  axi_r_t      r;
  logic        r_ready;
  logic [31:0] pc;
  logic        jmp_flush;
  logic        inst_valid;
  logic [31:0] inst;
  logic        inst_err;
  logic [1:0]  ar_delay;
  logic [1:0]  r_delay;
  logic [31:0] err_line;
  logic [31:0] delay_rnd;
  logic [31:0] jump_rnd;
  // AR requests seen, checked in order
  axi_ar_t     ar_log[$];
  axi_ar_t     exp_ar;
  // the old stream may still send one request after a jump
  logic [31:0] stale_line;
  logic        stale_ok;

  fetch_buffer DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_o         (ar),
    .ar_ready_i   (ar_ready),
    .r_i          (r),
    .r_ready_o    (r_ready),
    .pc_i         (pc),
    .jmp_flush_i  (jmp_flush),
    .inst_valid_o (inst_valid),
    .inst_o       (inst),
    .inst_err_o   (inst_err)
  );

  axi_line_memory #(.WORD_KEY(WORD_KEY)) u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_ready_i  (r_ready),
    .ar_delay_i (ar_delay),
    .r_delay_i  (r_delay),
    .err_line_i (err_line)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return addr ^ WORD_KEY;
  endfunction

  // ==================================================
  // clock, bus delays, AR monitor, watchdog
  // ==================================================
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(negedge clk) begin
    delay_rnd = xorshift(delay_rnd);
    ar_delay  = delay_rnd[1:0];
    r_delay   = delay_rnd[9:8];
  end

  // valid and ready both up mid-cycle, transfer on the next edge
  always @(negedge clk) begin
    if (!rst_n && ar.valid && ar_ready) begin
      ar_log.push_back(ar);
    end
  end

  initial begin
    repeat (TEST_STEPS * STEP_CYCLES + RESET_CYCLES) @(posedge clk);
    $display("watchdog expired before the tests finished");
    abort_run();
  end

  // ==================================================
  // compare tasks
  // ==================================================
  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error @ %0t: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ar(input axi_ar_t got, input axi_ar_t exp);
    if (got !== exp) begin
      $display("** Error @ %0t: ar_o.addr got %h expected %h", $time, got.addr, exp.addr);
      abort_run();
    end
  endtask

  task automatic check_inst(input logic [31:0] got, input logic got_err,
                            input logic [31:0] exp, input logic exp_err);
    if (got !== exp) begin
      $display("** Error @ %0t: inst_o got %h expected %h", $time, got, exp);
      abort_run();
    end else if (got_err !== exp_err) begin
      $display("** Error @ %0t: inst_err_o got %b expected %b", $time, got_err, exp_err);
      abort_run();
    end
  endtask

  // ==================================================
  // stimulus helpers
  // ==================================================
  task automatic drain_ar_log();
    axi_ar_t got;
    while (ar_log.size() > 0) begin
      got = ar_log.pop_front();
      if (!(stale_ok && got.addr == stale_line)) begin
        check_ar(got, exp_ar);
        exp_ar.addr = exp_ar.addr + 32'd16;
      end
      stale_ok = 1'b0;
    end
  endtask

  task automatic step_pc(input logic [31:0] addr, input logic jump);
    logic exp_err;
    int   waited;
    exp_err   = (addr[31:4] == err_line[31:4]);
    pc        = addr;
    jmp_flush = jump;
    @(negedge clk);
    if (jump) begin
      jmp_flush = 1'b0;
      @(negedge clk);
    end
    waited = 0;
    while (!inst_valid && waited < STEP_CYCLES) begin
      waited++;
      @(negedge clk);
    end
    if (!inst_valid) begin
      $display("inst_valid_o stayed low for pc %h", addr);
      abort_run();
    end else begin
      check_inst(inst, inst_err, word_at(addr), exp_err);
    end
  endtask

  task automatic jump_to(input logic [31:0] target);
    drain_ar_log();
    stale_line  = exp_ar.addr;
    stale_ok    = 1'b1;
    exp_ar.addr = {target[31:4], 4'h0};
    step_pc(target, 1'b1);
  endtask

  // ==================================================
  // directed tests
  // ==================================================
  task automatic reset_state();
    check_bit("ar_o.valid", ar.valid, 1'b0);
    check_bit("r_ready_o", r_ready, 1'b0);
    check_bit("inst_valid_o", inst_valid, 1'b0);
    rst_n = 1'b0;
    step_pc(RESET_PC, 1'b0);
    if (ar_log.size() == 0) begin
      $display("no AR request was seen after reset");
      abort_run();
    end else begin
      drain_ar_log();
    end
  endtask

  task automatic sequential_fetch();
    for (int i = 1; i < 12 * 4; i++) begin
      step_pc(RESET_PC + 32'(i * 4), 1'b0);
    end
    drain_ar_log();
  endtask

  task automatic prefetch_limit();
    int ahead;
    repeat (STEP_CYCLES / 2) @(negedge clk);
    drain_ar_log();
    // lines requested past the one the pc sits in
    ahead = int'((exp_ar.addr - {pc[31:4], 4'h0}) >> 4) - 1;
    if (ahead == 0 || ahead > Q_DEPTH) begin
      $display("prefetch ran %0d lines ahead of pc, limit is %0d", ahead, Q_DEPTH);
      abort_run();
    end else begin
      repeat (STEP_CYCLES / 4) @(negedge clk);
      if (ar_log.size() != 0) begin
        $display("AR requests went on with the queue full");
        abort_run();
      end
    end
  endtask

  task automatic jump_mid_read();
    logic [31:0] target;
    int          waited;
    for (int k = 0; k < 6; k++) begin
      jump_rnd = xorshift(jump_rnd);
      // every jump lands in its own region
      target = (32'h9000_0000 + (32'(k) << 24)) | (jump_rnd & 32'h000f_fff0);
      jump_to(target);
      if (k % 2 == 0) begin
        waited = 0;
        while (!r_ready && waited < STEP_CYCLES) begin
          waited++;
          @(negedge clk);
        end
        if (!r_ready) begin
          $display("no read was outstanding to jump into");
          abort_run();
        end
      end else begin
        for (int w = 1; w < 4; w++) begin
          step_pc(target + 32'(w * 4), 1'b0);
        end
        drain_ar_log();
      end
    end
  endtask

  // line before, the error line, line after
  task automatic error_flag();
    logic [31:0] base;
    base = {err_line[31:4], 4'h0} - 32'd16;
    jump_to(base);
    for (int i = 1; i < 12; i++) begin
      step_pc(base + 32'(i * 4), 1'b0);
    end
    drain_ar_log();
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b1;
    pc           = RESET_PC;
    jmp_flush    = 1'b0;
    ar_delay     = 2'd0;
    r_delay      = 2'd0;
    err_line     = ERR_LINE;
    delay_rnd    = SEED;
    jump_rnd     = SEED;
    exp_ar.valid = 1'b1;
    exp_ar.addr  = RESET_PC;
    stale_line   = 32'd0;
    stale_ok     = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset_state();
    sequential_fetch();
    prefetch_limit();
    jump_mid_read();
    error_flag();
    $display("** PASS **");
    $finish;
  end

endmodule

//--- verif/axi_line_memory.sv
`timescale 1ns/100ps

module axi_line_memory #(
  parameter logic [31:0] WORD_KEY = 32'h0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  axi_lite_pkg::axi_ar_t ar_i,
  output logic                  ar_ready_o,
  output axi_lite_pkg::axi_r_t  r_o,
  input  logic                  r_ready_i,
  input  logic [1:0]            ar_delay_i,
  input  logic [1:0]            r_delay_i,
  input  logic [31:0]           err_line_i
);
  import axi_lite_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA
  } state_e;

  state_e      state_q;
  logic [1:0]  cnt_q;
  logic [31:0] line_addr_q;

  // ==================================================
  // one read at a time, delay loaded per phase
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q     <= S_IDLE;
      cnt_q       <= 2'd0;
      line_addr_q <= 32'd0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (ar_i.valid) begin
            cnt_q   <= ar_delay_i;
            state_q <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (cnt_q != 2'd0) begin
            cnt_q <= cnt_q - 2'd1;
          end else begin
            // ready is up here, valid is held, so this is the handshake
            line_addr_q <= {ar_i.addr[31:4], 4'h0};
            cnt_q       <= r_delay_i;
            state_q     <= S_DATA;
          end
        end
        S_DATA: begin
          if (cnt_q != 2'd0) begin
            cnt_q <= cnt_q - 2'd1;
          end else if (r_ready_i) begin
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  assign ar_ready_o = (state_q == S_ADDR) && (cnt_q == 2'd0);

  // word at byte address A is A xor key
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      r_o.data[i*32 +: 32] = (line_addr_q + 32'(i * 4)) ^ WORD_KEY;
    end
    r_o.valid = (state_q == S_DATA) && (cnt_q == 2'd0);
    r_o.resp  = (line_addr_q[31:4] == err_line_i[31:4]) ? SLVERR : OKAY;
  end

endmodule

//--- rtl/fetch_buffer.sv
`timescale 1ns/100ps

module fetch_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  output axi_lite_pkg::axi_ar_t ar_o,
  input  logic                  ar_ready_i,
  input  axi_lite_pkg::axi_r_t  r_i,
  output logic                  r_ready_o,
  input  logic [31:0]           pc_i,
  input  logic                  jmp_flush_i,
  output logic                  inst_valid_o,
  output logic [31:0]           inst_o,
  output logic                  inst_err_o
);
  import fetch_pkg::*;

  // requester to queue
  logic             wr_en;
  q_entry_t         wr_entry;

  // queue to selector and requester
  q_entry_t         head;
  q_status_t        status;

  // selector control
  logic             pop;
  logic             flush;
  logic             restart;
  logic [TAG_W-1:0] restart_tag;

  line_requester u_line_requester (
    .clk           (clk),
    .rst_n         (rst_n),
    .ar_o          (ar_o),
    .ar_ready_i    (ar_ready_i),
    .r_i           (r_i),
    .r_ready_o     (r_ready_o),
    .status_i      (status),
    .restart_i     (restart),
    .restart_tag_i (restart_tag),
    .wr_en_o       (wr_en),
    .wr_entry_o    (wr_entry)
  );

  line_queue u_line_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en_i    (wr_en),
    .wr_entry_i (wr_entry),
    .pop_i      (pop),
    .flush_i    (flush),
    .head_o     (head),
    .status_o   (status)
  );

  inst_select u_inst_select (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_i          (pc_i),
    .jmp_flush_i   (jmp_flush_i),
    .head_i        (head),
    .status_i      (status),
    .pop_o         (pop),
    .flush_o       (flush),
    .restart_o     (restart),
    .restart_tag_o (restart_tag),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .inst_err_o    (inst_err_o)
  );

endmodule

//--- rtl/inst_select.sv
`timescale 1ns/100ps

module inst_select (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [31:0]                 pc_i,
  input  logic                        jmp_flush_i,
  input  fetch_pkg::q_entry_t         head_i,
  input  fetch_pkg::q_status_t        status_i,
  output logic                        pop_o,
  output logic                        flush_o,
  output logic                        restart_o,
  output logic [fetch_pkg::TAG_W-1:0] restart_tag_o,
  output logic                        inst_valid_o,
  output logic [31:0]                 inst_o,
  output logic                        inst_err_o
);
  import fetch_pkg::*;

  // line of the queue head
  logic [TAG_W-1:0] tag_q;
  logic [TAG_W-1:0] pc_tag;
  logic             tag_hit;
  logic             seq_step;

  assign pc_tag  = pc_i[TAG_W+LINE_OFS_W-1:LINE_OFS_W];
  assign tag_hit = (pc_tag == tag_q);

  // ==================================================
  // hold, pop or flush
  // ==================================================
  // next line only counts as sequential when there is a head to drop
  assign seq_step = (pc_tag == tag_q + 1'b1) && !status_i.empty;

  assign pop_o   = seq_step && !jmp_flush_i;
  assign flush_o = jmp_flush_i || (!tag_hit && !seq_step);

  // prefetch restarts at the pc's line
  assign restart_o     = flush_o;
  assign restart_tag_o = pc_tag;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      tag_q <= RESET_PC[TAG_W+LINE_OFS_W-1:LINE_OFS_W];
    end else if (pop_o || flush_o) begin
      tag_q <= pc_tag;
    end
  end

  // ==================================================
  // instruction output
  // ==================================================
  assign inst_valid_o = tag_hit && !status_i.empty && !jmp_flush_i;

  // word within the line from pc[3:2]
  assign inst_o     = head_i.line.words[pc_i[LINE_OFS_W-1:2]];
  assign inst_err_o = head_i.err;

endmodule

//--- rtl/line_queue.sv
`timescale 1ns/100ps

module line_queue (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_en_i,
  input  fetch_pkg::q_entry_t  wr_entry_i,
  input  logic                 pop_i,
  input  logic                 flush_i,
  output fetch_pkg::q_entry_t  head_o,
  output fetch_pkg::q_status_t status_o
);
  import fetch_pkg::*;

  q_entry_t           mem [Q_DEPTH];
  logic [Q_PTR_W-1:0] wr_ptr_q;
  logic [Q_PTR_W-1:0] rd_ptr_q;

  logic               ptr_empty;
  logic               ptr_full;
  logic               do_write;
  logic               do_pop;
  logic               bypass;

  // ==================================================
  // pointer compare
  // ==================================================
  assign ptr_empty = (wr_ptr_q == rd_ptr_q);

  // same index, opposite wrap bit
  assign ptr_full = (wr_ptr_q[Q_PTR_W-1] != rd_ptr_q[Q_PTR_W-1]) &&
                    (wr_ptr_q[Q_PTR_W-2:0] == rd_ptr_q[Q_PTR_W-2:0]);

  assign do_write = wr_en_i && !ptr_full;

  // the bypassed entry may be popped in its arrival cycle
  assign do_pop = pop_i && (!ptr_empty || do_write);

  assign bypass = ptr_empty && wr_en_i;

  // ==================================================
  // pointers and storage
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr_q[Q_PTR_W-2:0]] <= wr_entry_i;
    end
  end

  // ==================================================
  // head and status
  // ==================================================
  // write-through when nothing is stored yet
  assign head_o = bypass ? wr_entry_i : mem[rd_ptr_q[Q_PTR_W-2:0]];

  // head already usable during a bypass write
  assign status_o.empty = ptr_empty && !wr_en_i;
  assign status_o.full  = ptr_full;
  assign status_o.count = wr_ptr_q - rd_ptr_q;

endmodule

//--- rtl/line_requester.sv
`timescale 1ns/100ps

module line_requester (
  input  logic                        clk,
  input  logic                        rst_n,
  output axi_lite_pkg::axi_ar_t       ar_o,
  input  logic                        ar_ready_i,
  input  axi_lite_pkg::axi_r_t        r_i,
  output logic                        r_ready_o,
  input  fetch_pkg::q_status_t        status_i,
  input  logic                        restart_i,
  input  logic [fetch_pkg::TAG_W-1:0] restart_tag_i,
  output logic                        wr_en_o,
  output fetch_pkg::q_entry_t         wr_entry_o
);
  import axi_lite_pkg::*;
  import fetch_pkg::*;

  typedef enum logic {
    IDLE,
    WAIT_DATA
  } state_e;

  state_e                state_q;
  logic                  ar_valid_q;
  logic [AXI_ADDR_W-1:0] ar_addr_q;
  logic [TAG_W-1:0]      next_tag_q;
  logic                  stale_q;

  logic                  ar_hs;
  logic                  r_hs;
  logic                  in_flight;
  logic [Q_PTR_W:0]      occupancy;
  logic                  issue;

  // ==================================================
  // handshakes and issue decision
  // ==================================================
  assign ar_hs = ar_valid_q && ar_ready_i;
  assign r_hs  = r_i.valid && r_ready_o;

  // a pending address counts as outstanding too
  assign in_flight = ar_valid_q || (state_q == WAIT_DATA);

  // lines held plus the one on its way
  assign occupancy = {1'b0, status_i.count} + {{Q_PTR_W{1'b0}}, in_flight};

  // no issue in a restart cycle, next_tag_q is being reloaded
  assign issue = (state_q == IDLE) && !ar_valid_q && !restart_i &&
                 (occupancy < Q_DEPTH);

  // ==================================================
  // read FSM, one read outstanding
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (ar_hs) begin
            state_q <= WAIT_DATA;
          end
        end
        WAIT_DATA: begin
          if (r_hs) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // valid held until accepted
  always_ff @(posedge clk) begin
    if (rst_n) begin
      ar_valid_q <= 1'b0;
    end else if (issue) begin
      ar_valid_q <= 1'b1;
    end else if (ar_hs) begin
      ar_valid_q <= 1'b0;
    end
  end

  // address latched at issue, stable while valid is up
  always_ff @(posedge clk) begin
    if (issue) begin
      ar_addr_q <= {next_tag_q, {LINE_OFS_W{1'b0}}};
    end
  end

  // next line to prefetch
  always_ff @(posedge clk) begin
    if (rst_n) begin
      next_tag_q <= RESET_PC[TAG_W+LINE_OFS_W-1:LINE_OFS_W];
    end else if (restart_i) begin
      next_tag_q <= restart_tag_i;
    end else if (issue) begin
      next_tag_q <= next_tag_q + 1'b1;
    end
  end

  // read that belongs to the old stream, accept it and throw it away
  always_ff @(posedge clk) begin
    if (rst_n) begin
      stale_q <= 1'b0;
    end else if (r_hs) begin
      stale_q <= 1'b0;
    end else if (restart_i && in_flight) begin
      stale_q <= 1'b1;
    end
  end

  // ==================================================
  // outputs
  // ==================================================
  always_comb begin
    ar_o.valid = ar_valid_q;
    ar_o.addr  = ar_addr_q;
  end

  assign r_ready_o = (state_q == WAIT_DATA);

  // a beat landing in a restart cycle is dropped by the queue flush
  assign wr_en_o = r_hs && !stale_q;

  always_comb begin
    wr_entry_o.line.raw = r_i.data;
    wr_entry_o.err      = (r_i.resp != OKAY);
  end

endmodule

//--- rtl/fetch_pkg.sv
package fetch_pkg;

  // ==================================================
  // address split
  // ==================================================
  // byte offset bits inside one line
  localparam int LINE_OFS_W = 4;
  // pc[31:4]
  localparam int TAG_W = 28;
  localparam logic [31:0] RESET_PC = 32'h8000_0000;

  localparam int LINE_W = 128;
  localparam int WORD_W = 32;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;

  // ==================================================
  // queue geometry
  // ==================================================
  localparam int Q_DEPTH = 4;
  // two index bits plus wrap bit
  localparam int Q_PTR_W = 3;

  // raw for the bus side, words for instruction select
  typedef union packed {
    logic [LINE_W-1:0]                     raw;
    logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
  } line_t;

  // err set when the bus answered anything but OKAY
  typedef struct packed {
    line_t line;
    logic  err;
  } q_entry_t;

  typedef struct packed {
    logic             empty;
    logic             full;
    logic [Q_PTR_W-1:0] count;
  } q_status_t;

endpackage

//--- rtl/axi_lite_pkg.sv
package axi_lite_pkg;

  // ==================================================
  // bus widths
  // ==================================================
  localparam int AXI_ADDR_W = 32;
  // one whole cache line per beat
  localparam int AXI_DATA_W = 128;

  // ==================================================
  // read channel types
  // ==================================================
  // response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // read address channel, master to slave
  typedef struct packed {
    logic                  valid;
    logic [AXI_ADDR_W-1:0] addr;
  } axi_ar_t;

  // read data channel, slave to master
  typedef struct packed {
    logic                  valid;
    logic [AXI_DATA_W-1:0] data;
    axi_resp_e             resp;
  } axi_r_t;

endpackage
